// ==== list.f ====
+incdir+common
common/isa_pkg.sv
common/pipe_pkg.sv
hw/stage_reg.sv
hw/fetch_unit.sv
hw/decode_stage.sv
execute/alu.sv
execute/execute_stage.sv
hw/mem_wb_stage.sv
hw/core_top.sv
tests/core_assertions.sv
tests/tb_clock_gen.sv
tests/tb_top.sv

// ==== tests/tb_top.sv ====
// Testbench top with memory and register file models, golden model, write checks and timeout
`timescale 1ns/100ps

module tb_top
    import isa_pkg::*;
    import pipe_pkg::*;
();

    localparam int PROG_LEN       = 26;
    localparam int TIMEOUT_CYCLES = 5 * PROG_LEN + 50;

    logic      clock;
    logic      rst_n;
    word_t     imem_addr;
    word_t     imem_data;
    dmem_req_t dmem_req;
    word_t     dmem_rdata;
    rf_read_t  rf_read;
    word_t     rf_data_a;
    word_t     rf_data_b;
    rf_write_t rf_write;

    word_t       rom [64];
    word_t       ram [64];
    word_t       rf [32];
    word_t       gmem [64];   // Golden copies
    word_t       gregs [32];
    rf_write_t   exp_wr [$];
    dmem_req_t   exp_st [$];
    rf_write_t   pend_rf = '0;
    dmem_req_t   pend_st = '0;
    int          wr_idx  = 0;
    int          st_idx  = 0;
    int          cycles  = 0;
    logic [31:0] lfsr    = 32'h39b1ea14;

    tb_clock_gen clock_gen_i (
        .clock_o (clock),
        .rst_n_o (rst_n)
    );

    core_top core_top_i (
        .clock        (clock),
        .rst_n_i      (rst_n),
        .imem_addr_o  (imem_addr),
        .imem_data_i  (imem_data),
        .dmem_req_o   (dmem_req),
        .dmem_rdata_i (dmem_rdata),
        .rf_read_o    (rf_read),
        .rf_data_a_i  (rf_data_a),
        .rf_data_b_i  (rf_data_b),
        .rf_write_o   (rf_write)
    );

    function automatic logic [31:0] lfsr_next(logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);  // Galois form
    endfunction

    // Eight LFSR bits sign-extended to 17
    function automatic logic [16:0] random_imm();
        logic [7:0] v;
        for (int k = 0; k < 8; k++) begin
            v[k] = lfsr[0];
            lfsr = lfsr_next(lfsr);
        end
        return {{9{v[7]}}, v};
    endfunction

    function automatic word_t enc_r(alu_op_e fn, reg_addr_t rd, reg_addr_t rs, reg_addr_t rt,
                                    logic [4:0] sh);
        return {OP_RTYPE, rd, rs, rt, sh, fn, 2'b00};
    endfunction

    function automatic word_t enc_i(opcode_e op, reg_addr_t rd, reg_addr_t rs, logic [16:0] imm);
        return {op, rd, rs, imm};
    endfunction

    function automatic word_t enc_j(logic [26:0] target);
        return {OP_J, target};
    endfunction

    function automatic word_t mem_fill(int a);
        return 32'hC0DE_0000 ^ (word_t'(a) * 32'h9E37_79B1);
    endfunction

    function automatic word_t reg_init(int i);
        return (i == 0) ? '0 : 32'h100 + i;
    endfunction

    function automatic word_t rf_read_value(reg_addr_t a);
        if (a == '0) begin
            return '0;
        end
        if (rf_write.we && (rf_write.addr == a)) begin
            return rf_write.data;  // Write-first
        end
        return rf[a];
    endfunction

    function automatic void golden_write(reg_addr_t rd, word_t v);
        if (rd != '0) begin
            gregs[rd] = v;
            exp_wr.push_back('{we: 1'b1, addr: rd, data: v});
        end
    endfunction

    task automatic report_failure(string line);
        $display("%s", line);
        $display("TEST RESULT: FAIL");
        $fatal(1, "Simulation stopped at first error");
    endtask

    task automatic load_program();
        foreach (rom[i]) begin
            rom[i] = '0;  // Unused words decode as add r0
        end
        rom[0]  = enc_i(OP_ADDI, 1, 0, random_imm());
        rom[1]  = enc_i(OP_ADDI, 2, 1, random_imm());
        rom[2]  = enc_r(ADD, 3, 1, 2, 0);
        rom[3]  = enc_r(SUB, 4, 3, 1, 0);
        rom[4]  = enc_r(SLL, 5, 4, 0, 3);
        rom[5]  = enc_r(SRA, 6, 5, 0, 2);
        rom[6]  = enc_r(AND, 7, 6, 3, 0);
        rom[7]  = enc_r(OR, 8, 7, 2, 0);
        rom[8]  = enc_i(OP_ADDI, 0, 8, random_imm());  // Aimed at r0
        rom[9]  = enc_r(ADD, 9, 0, 8, 0);
        rom[10] = enc_i(OP_SW, 9, 0, 17'd10);
        rom[11] = enc_i(OP_LW, 10, 0, 17'd10);
        rom[12] = enc_r(ADD, 11, 10, 1, 0);             // Load-use
        rom[13] = enc_i(OP_LW, 12, 0, 17'd3);
        rom[14] = enc_i(OP_SW, 12, 0, 17'd20);          // Store of loaded value
        rom[15] = enc_i(OP_BNE, 12, 10, 17'd1);
        rom[16] = enc_i(OP_ADDI, 15, 0, 17'd77);
        rom[17] = enc_i(OP_ADDI, 14, 0, 17'h1fffd);     // -3
        rom[18] = enc_i(OP_BLT, 14, 0, 17'd1);
        rom[19] = enc_i(OP_ADDI, 16, 0, 17'd88);
        rom[20] = enc_i(OP_BLT, 0, 14, 17'd1);
        rom[21] = enc_i(OP_BNE, 14, 14, 17'd1);
        rom[22] = enc_j(27'd24);
        rom[23] = enc_i(OP_ADDI, 17, 0, 17'd55);
        rom[24] = enc_i(OP_ADDI, 20, 20, random_imm());
        rom[25] = enc_j(27'd25);                        // Parks the core
    endtask

    // Instruction-level model of the ISA rules
    task automatic run_golden();
        word_t     w;
        word_t     pc;
        word_t     imm;
        word_t     vs;
        word_t     vt;
        word_t     vd;
        word_t     addr;
        reg_addr_t rd;
        logic      halted;
        pc = '0;
        halted = 1'b0;
        for (int step = 0; (step < 4 * PROG_LEN) && !halted; step++) begin
            w    = rom[pc[5:0]];
            rd   = w[26:22];
            vs   = gregs[w[21:17]];
            vt   = gregs[w[16:12]];
            vd   = gregs[rd];
            imm  = {{15{w[16]}}, w[16:0]};
            addr = vs + imm;
            pc   = pc + 1;  // Branch offsets count from here
            case (w[31:27])
                OP_RTYPE: begin
                    case (w[6:2])
                        ADD:     golden_write(rd, vs + vt);
                        SUB:     golden_write(rd, vs - vt);
                        AND:     golden_write(rd, vs & vt);
                        OR:      golden_write(rd, vs | vt);
                        SLL:     golden_write(rd, vs << w[11:7]);
                        SRA:     golden_write(rd, $signed(vs) >>> w[11:7]);
                        default: ;
                    endcase
                end
                OP_ADDI: golden_write(rd, addr);
                OP_LW:   golden_write(rd, gmem[addr[5:0]]);
                OP_SW: begin
                    exp_st.push_back('{addr: addr, wdata: vd, we: 1'b1});
                    gmem[addr[5:0]] = vd;
                end
                OP_BNE: pc = (vd != vs) ? pc + imm : pc;
                OP_BLT: pc = ($signed(vd) < $signed(vs)) ? pc + imm : pc;
                OP_J: begin
                    halted = ({5'b0, w[26:0]} == pc - 1);  // Jump to itself
                    pc = {5'b0, w[26:0]};
                end
                default: ;
            endcase
        end
    endtask

    task automatic check_writes();
        assert (core_top_i.port_checks.fail_count == 0)
            else report_failure("A bound port assertion in core_assertions failed");
        if (rf_write.we) begin
            assert ((wr_idx < exp_wr.size()) && (rf_write == exp_wr[wr_idx])) begin
                wr_idx++;
            end else begin
                report_failure($sformatf("FAIL @%0t: write r%0d = %h is not golden write %0d of %0d",
                               $time, rf_write.addr, rf_write.data, wr_idx, exp_wr.size()));
            end
        end
        if (dmem_req.we) begin
            assert ((st_idx < exp_st.size()) && (dmem_req == exp_st[st_idx])) begin
                st_idx++;
            end else begin
                report_failure($sformatf("FAIL @%0t: store [%h] = %h is not golden store %0d of %0d",
                               $time, dmem_req.addr, dmem_req.wdata, st_idx, exp_st.size()));
            end
        end
    endtask

    // Requests are stable mid-cycle and answers settle before the next rising edge
    always @(negedge clock) begin
        imem_data  = (imem_addr < 64) ? rom[imem_addr[5:0]] : '0;
        rf_data_a  = rf_read_value(rf_read.addr_a);
        rf_data_b  = rf_read_value(rf_read.addr_b);
        dmem_rdata = ram[dmem_req.addr[5:0]];
        if (rst_n) begin
            pend_rf = rf_write;
            pend_st = dmem_req;
            check_writes();
        end
    end

    always @(posedge clock) begin
        if (pend_rf.we) begin
            rf[pend_rf.addr] <= pend_rf.data;
        end
        if (pend_st.we) begin
            ram[pend_st.addr[5:0]] <= pend_st.wdata;
        end
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            report_failure($sformatf("Timeout: program did not finish within %0d cycles",
                           TIMEOUT_CYCLES));
        end
    end

    initial begin
        imem_data  = '0;
        dmem_rdata = '0;
        rf_data_a  = '0;
        rf_data_b  = '0;
        foreach (ram[i]) begin
            ram[i]  = mem_fill(i);
            gmem[i] = mem_fill(i);
        end
        foreach (rf[i]) begin
            rf[i]    = reg_init(i);
            gregs[i] = reg_init(i);
        end
        load_program();
        run_golden();
        while (!(rst_n && (wr_idx == exp_wr.size()) && (st_idx == exp_st.size()))) begin
            @(negedge clock);
        end
        repeat (10) @(negedge clock);  // Late extra writes still get checked
        if (core_top_i.port_checks.fail_count == 0) begin
            $display("TEST RESULT: PASS");
            $finish;
        end else begin
            report_failure("A bound port assertion in core_assertions failed");
        end
    end

endmodule

// ==== tests/tb_clock_gen.sv ====
// Testbench clock and active-low reset generator
`timescale 1ns/100ps

module tb_clock_gen #(
    parameter int HALF_PERIOD  = 10,  // 20 ns period
    parameter int RESET_CYCLES = 2
) (
    output logic clock_o,
    output logic rst_n_o
);

    initial begin
        clock_o = 1'b0;
        forever #HALF_PERIOD clock_o = ~clock_o;
    end

    initial begin
        rst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clock_o);
        @(negedge clock_o);  // Release between edges
        rst_n_o = 1'b1;
    end

endmodule

// ==== tests/core_assertions.sv ====
// Concurrent checks on the register file and data memory write ports, bound to core_top
`timescale 1ns/100ps

module core_assertions
    import pipe_pkg::*;
(
    input logic      clock,
    input logic      rst_n_i,
    input rf_write_t rf_write_i,
    input dmem_req_t dmem_req_i
);

    int unsigned fail_count = 0;  // Failed assertion count

    // Covers every reset cycle and the first cycle after release
    reset_quiet: assert property (@(posedge clock) !rst_n_i |=> !rf_write_i.we && !dmem_req_i.we)
        else begin
            $error("Write enable active during reset or right after it");
            fail_count++;
        end

    rf_write_clean: assert property (@(posedge clock) disable iff (!rst_n_i)
        rf_write_i.we |-> (rf_write_i.addr != '0) && !$isunknown(rf_write_i.data))
        else begin
            $error("Register write to r0 or with unknown data");
            fail_count++;
        end

    store_clean: assert property (@(posedge clock) disable iff (!rst_n_i)
        dmem_req_i.we |-> !$isunknown(dmem_req_i.addr) && !$isunknown(dmem_req_i.wdata))
        else begin
            $error("Store with unknown address or data");
            fail_count++;
        end

endmodule

bind core_top core_assertions port_checks (
    .clock      (clock),
    .rst_n_i    (rst_n_i),
    .rf_write_i (rf_write_o),
    .dmem_req_i (dmem_req_o)
);

// ==== hw/core_top.sv ====
// Five-stage core top level with stages and stage registers
`timescale 1ns/100ps
`include "core_settings.svh"

module core_top
    import pipe_pkg::*;
(
    input  logic             clock,
    input  logic             rst_n_i,
    output logic [`XLEN-1:0] imem_addr_o,
    input  logic [`XLEN-1:0] imem_data_i,
    output dmem_req_t        dmem_req_o,
    input  logic [`XLEN-1:0] dmem_rdata_i,
    output rf_read_t         rf_read_o,
    input  logic [`XLEN-1:0] rf_data_a_i,
    input  logic [`XLEN-1:0] rf_data_b_i,
    output rf_write_t        rf_write_o
);

    fd_t       fd_d;
    fd_t       fd_q;
    dx_t       dx_d;
    dx_t       dx_q;
    xm_t       xm_d;
    xm_t       xm_q;
    mw_t       mw_d;
    mw_t       mw_q;
    logic      stall;
    redirect_t redirect;

    fetch_unit fetch_i (
        .clock       (clock),
        .rst_n_i     (rst_n_i),
        .stall_i     (stall),
        .redirect_i  (redirect),
        .imem_addr_o (imem_addr_o),
        .imem_data_i (imem_data_i),
        .fd_o        (fd_d)
    );

    stage_reg #(.payload_t(fd_t)) fd_reg (
        .clock   (clock),
        .rst_n_i (rst_n_i),
        .hold_i  (stall),           // Load-use holds the same instruction
        .flush_i (redirect.taken),
        .d_i     (fd_d),
        .q_o     (fd_q)
    );

    decode_stage decode_i (
        .fd_i        (fd_q),
        .dx_instr_i  (dx_q.instr),
        .rf_read_o   (rf_read_o),
        .rf_data_a_i (rf_data_a_i),
        .rf_data_b_i (rf_data_b_i),
        .stall_o     (stall),
        .dx_o        (dx_d)
    );

    stage_reg #(.payload_t(dx_t)) dx_reg (
        .clock   (clock),
        .rst_n_i (rst_n_i),
        .hold_i  (1'b0),
        .flush_i (redirect.taken),  // Second shadow slot
        .d_i     (dx_d),
        .q_o     (dx_q)
    );

    execute_stage execute_i (
        .dx_i       (dx_q),
        .xm_i       (xm_q),
        .wb_i       (rf_write_o),
        .xm_o       (xm_d),
        .redirect_o (redirect)
    );

    stage_reg #(.payload_t(xm_t)) xm_reg (
        .clock   (clock),
        .rst_n_i (rst_n_i),
        .hold_i  (1'b0),
        .flush_i (1'b0),
        .d_i     (xm_d),
        .q_o     (xm_q)
    );

    mem_wb_stage mem_wb_i (
        .xm_i         (xm_q),
        .mw_i         (mw_q),
        .dmem_req_o   (dmem_req_o),
        .dmem_rdata_i (dmem_rdata_i),
        .rf_write_o   (rf_write_o),
        .mw_o         (mw_d)
    );

    stage_reg #(.payload_t(mw_t)) mw_reg (
        .clock   (clock),
        .rst_n_i (rst_n_i),
        .hold_i  (1'b0),
        .flush_i (1'b0),
        .d_i     (mw_d),
        .q_o     (mw_q)
    );

endmodule

// ==== hw/mem_wb_stage.sv ====
// Data memory request, store-data forwarding and writeback selection
`timescale 1ns/100ps

module mem_wb_stage
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  xm_t       xm_i,
    input  mw_t       mw_i,
    output dmem_req_t dmem_req_o,
    input  word_t     dmem_rdata_i,
    output rf_write_t rf_write_o,
    output mw_t       mw_o
);

    logic is_store;
    logic wm_fwd;

    assign is_store = (xm_i.instr.opcode == OP_SW);

    // Writeback is producing the register being stored
    assign wm_fwd = is_store && rf_write_o.we && (rf_write_o.addr == xm_i.instr.rd);

    assign dmem_req_o = '{
        addr:  xm_i.result,
        wdata: wm_fwd ? rf_write_o.data : xm_i.store_data,
        we:    is_store
    };

    assign mw_o = '{instr: xm_i.instr, result: xm_i.result, load_data: dmem_rdata_i};

    assign rf_write_o = '{
        we:   writes_rd(mw_i.instr) && (mw_i.instr.rd != '0),  // r0 stays zero
        addr: mw_i.instr.rd,
        data: (mw_i.instr.opcode == OP_LW) ? mw_i.load_data : mw_i.result
    };

endmodule

// ==== execute/execute_stage.sv ====
// Execute stage with operand forwarding, ALU and branch resolution
`timescale 1ns/100ps

module execute_stage
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  dx_t       dx_i,
    input  xm_t       xm_i,
    input  rf_write_t wb_i,
    output xm_t       xm_o,
    output redirect_t redirect_o
);

    instr_t  instr;
    word_t   imm;
    word_t   ra_val;
    word_t   rb_val;
    word_t   alu_a;
    word_t   alu_b;
    word_t   alu_res;
    alu_op_e alu_op;
    logic    is_branch;
    logic    use_imm;
    logic    ne;
    logic    lt;
    logic    taken;

    // Youngest producer of src wins
    function automatic word_t fwd(reg_addr_t src, word_t dx_val, xm_t xm, rf_write_t wb);
        logic mx_hit;
        mx_hit = (src != '0) && writes_rd(xm.instr) && (xm.instr.rd == src) &&
                 (xm.instr.opcode != OP_LW);  // A load in X/M holds only its address
        if (mx_hit) begin
            return xm.result;
        end
        if (wb.we && (wb.addr == src)) begin
            return wb.data;
        end
        return dx_val;
    endfunction

    assign instr = dx_i.instr;
    assign imm   = imm_sext(instr);

    assign ra_val = fwd(instr.rs, dx_i.opa, xm_i, wb_i);
    assign rb_val = fwd(src_b(instr), dx_i.opb, xm_i, wb_i);

    assign is_branch = instr.opcode inside {OP_BNE, OP_BLT};
    assign use_imm   = instr.opcode inside {OP_ADDI, OP_LW, OP_SW};

    // Branches compare $rd against $rs
    assign alu_a  = is_branch ? rb_val : ra_val;
    assign alu_b  = is_branch ? ra_val : (use_imm ? imm : rb_val);
    assign alu_op = (instr.opcode == OP_RTYPE) ? instr.alu_op : ADD;

    alu alu_i (
        .a_i      (alu_a),
        .b_i      (alu_b),
        .op_i     (alu_op),
        .shamt_i  (instr.shamt),
        .result_o (alu_res),
        .ne_o     (ne),
        .lt_o     (lt)
    );

    assign taken = (instr.opcode == OP_J) ||
                   ((instr.opcode == OP_BNE) && ne) ||
                   ((instr.opcode == OP_BLT) && lt);

    assign redirect_o = '{
        taken:  taken,
        target: (instr.opcode == OP_J) ? jump_target(instr) : dx_i.pc + word_t'(1) + imm
    };

    assign xm_o = '{instr: instr, result: alu_res, store_data: rb_val};  // rb_val is $rd for sw

endmodule

// ==== execute/alu.sv ====
// ALU with add, sub, logic and shift operations and compare flags
`timescale 1ns/100ps

module alu
    import isa_pkg::*;
(
    input  word_t      a_i,
    input  word_t      b_i,
    input  alu_op_e    op_i,
    input  logic [4:0] shamt_i,
    output word_t      result_o,
    output logic       ne_o,
    output logic       lt_o
);

    always_comb begin
        case (op_i)
            ADD:     result_o = a_i + b_i;
            SUB:     result_o = a_i - b_i;
            AND:     result_o = a_i & b_i;
            OR:      result_o = a_i | b_i;
            SLL:     result_o = a_i << shamt_i;
            SRA:     result_o = word_t'($signed(a_i) >>> shamt_i);
            default: result_o = '0;  // Unused encodings
        endcase
    end

    // Branch flags
    assign ne_o = (a_i != b_i);
    assign lt_o = ($signed(a_i) < $signed(b_i));

endmodule

// ==== hw/decode_stage.sv ====
// Decode stage with register file read requests and load-use detection
`timescale 1ns/100ps

module decode_stage
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  fd_t      fd_i,
    input  instr_t   dx_instr_i,
    output rf_read_t rf_read_o,
    input  word_t    rf_data_a_i,
    input  word_t    rf_data_b_i,
    output logic     stall_o,
    output dx_t      dx_o
);

    instr_t instr;
    logic   uses_a;
    logic   uses_b;
    logic   load_in_x;

    assign instr = fd_i.instr;

    assign rf_read_o = '{addr_a: instr.rs, addr_b: src_b(instr)};

    assign uses_a = (instr.opcode != OP_J);
    // Store data register is covered by WM forwarding instead
    assign uses_b = instr.opcode inside {OP_RTYPE, OP_BNE, OP_BLT};

    assign load_in_x = (dx_instr_i.opcode == OP_LW) && (dx_instr_i.rd != '0);

    assign stall_o = load_in_x &&
                     ((uses_a && (dx_instr_i.rd == rf_read_o.addr_a)) ||
                      (uses_b && (dx_instr_i.rd == rf_read_o.addr_b)));

    always_comb begin
        dx_o = '0;  // Bubble while stalled
        if (!stall_o) begin
            dx_o.pc    = fd_i.pc;
            dx_o.instr = instr;
            dx_o.opa   = rf_data_a_i;
            dx_o.opb   = rf_data_b_i;
        end
    end

endmodule

// ==== hw/fetch_unit.sv ====
// Program counter and next-PC selection
`timescale 1ns/100ps
`include "core_settings.svh"

module fetch_unit
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  logic      clock,
    input  logic      rst_n_i,
    input  logic      stall_i,
    input  redirect_t redirect_i,
    output word_t     imem_addr_o,
    input  word_t     imem_data_i,
    output fd_t       fd_o
);

    word_t pc;

    always_ff @(posedge clock) begin
        if (!rst_n_i) begin
            pc <= word_t'(`RESET_PC);
        end else if (redirect_i.taken) begin
            pc <= redirect_i.target;  // Branch or jump from execute
        end else if (!stall_i) begin
            pc <= pc + word_t'(1);
        end
    end

    assign imem_addr_o = pc;  // Word addressed

    // Fetched word travels with its own PC
    assign fd_o = '{pc: pc, instr: instr_t'(imem_data_i)};

endmodule

// ==== hw/stage_reg.sv ====
// Pipeline stage register with stall hold and flush to bubble
`timescale 1ns/100ps

module stage_reg
    import isa_pkg::*;
#(
    parameter type payload_t = instr_t
) (
    input  logic     clock,
    input  logic     rst_n_i,
    input  logic     hold_i,
    input  logic     flush_i,
    input  payload_t d_i,
    output payload_t q_o
);

    // All-zero payload decodes as add r0, which writes nothing
    always_ff @(posedge clock) begin
        if (!rst_n_i || flush_i) begin
            q_o <= '0;
        end else if (!hold_i) begin
            q_o <= d_i;
        end
    end

endmodule

// ==== common/pipe_pkg.sv ====
// Stage register payloads, redirect, memory and register file port structs
package pipe_pkg;

    import isa_pkg::*;

    typedef struct packed {
        word_t  pc;
        instr_t instr;
    } fd_t;

    typedef struct packed {
        word_t  pc;
        instr_t instr;
        word_t  opa;    // Value of rs
        word_t  opb;    // Value of rt or rd
    } dx_t;

    typedef struct packed {
        instr_t instr;
        word_t  result;      // ALU result or memory address
        word_t  store_data;
    } xm_t;

    typedef struct packed {
        instr_t instr;
        word_t  result;
        word_t  load_data;
    } mw_t;

    typedef struct packed {
        word_t addr;
        word_t wdata;
        logic  we;
    } dmem_req_t;

    typedef struct packed {
        reg_addr_t addr_a;
        reg_addr_t addr_b;
    } rf_read_t;

    typedef struct packed {
        logic      we;
        reg_addr_t addr;
        word_t     data;
    } rf_write_t;

    typedef struct packed {
        logic  taken;
        word_t target;
    } redirect_t;

endpackage

// ==== common/isa_pkg.sv ====
// ISA word types, opcode and ALU encodings, instruction format and field helpers
`include "core_settings.svh"

package isa_pkg;

    typedef logic [`XLEN-1:0]   word_t;
    typedef logic [`REG_AW-1:0] reg_addr_t;

    typedef enum logic [4:0] {
        OP_RTYPE = 5'b00000,
        OP_J     = 5'b00001,
        OP_BNE   = 5'b00010,
        OP_ADDI  = 5'b00101,
        OP_BLT   = 5'b00110,
        OP_SW    = 5'b00111,
        OP_LW    = 5'b01000
    } opcode_e;

    typedef enum logic [4:0] {
        ADD = 5'b00000,
        SUB = 5'b00001,
        AND = 5'b00010,
        OR  = 5'b00011,
        SLL = 5'b00100,
        SRA = 5'b00101
    } alu_op_e;

    typedef struct packed {
        opcode_e    opcode;  // [31:27]
        reg_addr_t  rd;      // [26:22]
        reg_addr_t  rs;      // [21:17]
        reg_addr_t  rt;      // [16:12], R-type only
        logic [4:0] shamt;   // [11:7]
        alu_op_e    alu_op;  // [6:2]
        logic [1:0] pad;
    } instr_t;

    // I-type immediate, bits [16:0]
    function automatic word_t imm_sext(instr_t i);
        logic [31:0] raw;
        raw = i;
        return {{(`XLEN-17){raw[16]}}, raw[16:0]};
    endfunction

    function automatic word_t jump_target(instr_t i);
        logic [31:0] raw;
        raw = i;
        return {{(`XLEN-27){1'b0}}, raw[26:0]};  // Zero-extended
    endfunction

    function automatic logic writes_rd(instr_t i);
        return i.opcode inside {OP_RTYPE, OP_ADDI, OP_LW};
    endfunction

    // Register read on port B
    function automatic reg_addr_t src_b(instr_t i);
        return (i.opcode == OP_RTYPE) ? i.rt : i.rd;
    endfunction

endpackage

// ==== common/core_settings.svh ====
// Core width, register address width and reset PC macros
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// Data path and address width in bits
`define XLEN 32

// Register file has 32 entries
`define REG_AW 5

// Word address of the first fetch
`define RESET_PC 0

`endif
